/* design/vdisp_pkg.sv */
//====================
// Sizes assume VLEN=512 and ELEN=64
// VL_W must hold every value from 0 to VLEN
//====================
`default_nettype none

package vdisp_pkg;

  localparam int unsigned XLEN  = 64;
  localparam int unsigned VLEN  = 512;
  localparam int unsigned VLENB = VLEN / 8;
  localparam int unsigned ELENB = 8;
  localparam int unsigned VL_W  = $clog2(VLEN + 1);

  typedef logic [VL_W-1:0] vlen_t;

  // Element width, log2 of the size in bytes
  typedef enum logic [2:0] {
    EW8  = 3'd0,
    EW16 = 3'd1,
    EW32 = 3'd2,
    EW64 = 3'd3
  } vew_e;

  // LMUL is the signed value {vlmul2, vlmul}
  typedef struct packed {
    logic       vill;
    logic       vma;
    logic       vta;
    logic       vlmul2;
    vew_e       vsew;
    logic [1:0] vlmul;
  } vtype_t;

  typedef enum logic [2:0] {
    VADD,
    VLE,
    VLSE,
    VLXE,
    VSE,
    VSSE,
    VSXE
  } ara_op_e;

  typedef struct packed {
    ara_op_e         op;
    logic [4:0]      vs1;
    logic [4:0]      vs2;
    logic [4:0]      vd;
    logic            use_vs1;
    logic            use_vs2;
    logic            use_vd;
    logic            vm;
    logic [XLEN-1:0] scalar_op;
    logic [XLEN-1:0] stride;
    vlen_t           vl;
    vlen_t           vstart;
    vtype_t          vtype;
  } ara_req_t;

  // Major opcodes
  localparam logic [6:0] OPC_VEC      = 7'b1010111;
  localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
  localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

  // funct3 inside OPC_VEC
  localparam logic [2:0] F3_OPCFG = 3'b111;
  localparam logic [2:0] F3_OPIVV = 3'b000;

  localparam logic [11:0] CSR_VSTART = 12'h008;
  localparam logic [11:0] CSR_VL     = 12'hC20;
  localparam logic [11:0] CSR_VTYPE  = 12'hC21;
  localparam logic [11:0] CSR_VLENB  = 12'hC22;

endpackage

`default_nettype wire

/* design/vdisp_verdict_if.sv */
//====================
// One unit's answer on the current instruction
// go is high only when the core can take a response
//====================
`timescale 1ns/1ps
`default_nettype none

interface vdisp_verdict_if;
  import vdisp_pkg::*;

  logic            claim;
  logic            ready;
  logic            resp_valid;
  logic            error;
  logic [XLEN-1:0] result;
  logic            go;

  modport unit (output claim, ready, resp_valid, error, result, input go);
  modport ack (input claim, ready, resp_valid, error, result, output go);

endinterface

`default_nettype wire

/* design/vcsr_unit.sv */
//====================
// vsetvli/vsetvl and CSR access to vstart, vl, vtype, vlenb
// Only the low 8 bits of the new vtype are used, reserved bits ignored
// Always answers in the cycle it is asked
//====================
`timescale 1ns/1ps
`default_nettype none

module vcsr_unit (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [31:0]                insn_i,
  input  logic [vdisp_pkg::XLEN-1:0] rs1_i,
  input  logic [vdisp_pkg::XLEN-1:0] rs2_i,
  vdisp_verdict_if.unit              verdict,
  output vdisp_pkg::vlen_t           vl_o,
  output vdisp_pkg::vlen_t           vstart_o,
  output vdisp_pkg::vtype_t          vtype_o
);
  import vdisp_pkg::*;

  vlen_t             vstart_q, vstart_d;
  vlen_t             vl_q, vl_d;
  vtype_t            vtype_q, vtype_d;
  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [4:0]        rs1_idx;
  logic [4:0]        rd_idx;
  logic [11:0]       csr_addr;
  logic [XLEN-1:0]   csr_src;
  logic              is_cfg;
  logic              is_csr;
  logic              claim;
  logic              err;
  logic [XLEN-1:0]   result;
  vtype_t            vt_new;
  logic signed [2:0] lmul;
  logic              vt_bad;
  vlen_t             vlmax;

  // Full CSR view of vtype, vill sits in the MSB
  function automatic logic [XLEN-1:0] vtype_to_xlen(vtype_t vt);
    return {vt.vill, {(XLEN - 9){1'b0}}, vt.vma, vt.vta, vt.vlmul2, vt.vsew, vt.vlmul};
  endfunction

  function automatic vtype_t vtype_from_byte(logic [7:0] b);
    vtype_t vt;
    vt.vill   = 1'b0;
    vt.vma    = b[7];
    vt.vta    = b[6];
    vt.vlmul2 = b[5];
    vt.vsew   = vew_e'(b[4:2]);
    vt.vlmul  = b[1:0];
    return vt;
  endfunction

  assign opcode   = insn_i[6:0];
  assign rd_idx   = insn_i[11:7];
  assign funct3   = insn_i[14:12];
  assign rs1_idx  = insn_i[19:15];
  assign csr_addr = insn_i[31:20];
  assign is_cfg   = (opcode == OPC_VEC) && (funct3 == F3_OPCFG);
  assign is_csr   = (opcode == OPC_SYSTEM);
  assign claim    = is_cfg || is_csr;

  // Immediate forms take the rs1 field as a 5-bit zero-extended value
  assign csr_src = funct3[2] ? XLEN'(rs1_idx) : rs1_i;

  // New vtype check and VLMAX = LMUL * VLEN / SEW
  always_comb begin
    if (!insn_i[31]) begin
      vt_new = vtype_from_byte(insn_i[27:20]);
    end else begin
      vt_new = vtype_from_byte(rs2_i[7:0]);
    end
    lmul   = {vt_new.vlmul2, vt_new.vlmul};
    vt_bad = (vt_new.vsew > EW64) || (lmul == 3'sb100) ||
             ($clog2(ELENB) + int'(lmul) < int'(vt_new.vsew));
    if (!vt_new.vlmul2) begin
      vlmax = vlen_t'((VLENB >> vt_new.vsew) << vt_new.vlmul);
    end else begin
      // Fractional LMUL, shift by 4 - vlmul
      vlmax = vlen_t'((VLENB >> vt_new.vsew) >> (3'd4 - {1'b0, vt_new.vlmul}));
    end
  end

  always_comb begin
    vstart_d = vstart_q;
    vl_d     = vl_q;
    vtype_d  = vtype_q;
    err      = 1'b0;
    result   = '0;
    if (is_cfg) begin
      if (!insn_i[31] || insn_i[31:25] == 7'b100_0000) begin
        if (vt_bad) begin
          vtype_d = vtype_t'({1'b1, 8'b0});
          vl_d    = '0;
        end else begin
          vtype_d = vt_new;
          if (rs1_idx == '0 && rd_idx == '0) begin
            vl_d = vl_q;
          end else if (rs1_idx == '0) begin
            vl_d = vlmax;
          end else begin
            vl_d = (rs1_i > XLEN'(vlmax)) ? vlmax : vlen_t'(rs1_i);
          end
        end
        result = XLEN'(vl_d);
      end else begin
        err = 1'b1;
      end
    end else if (is_csr) begin
      case (funct3)
        // csrrw, csrrwi: only vstart is writable
        3'b001, 3'b101: begin
          if (csr_addr == CSR_VSTART) begin
            vstart_d = vlen_t'(csr_src);
            result   = XLEN'(vstart_q);
          end else begin
            err = 1'b1;
          end
        end
        3'b010, 3'b011, 3'b110, 3'b111: begin
          case (csr_addr)
            CSR_VSTART: begin
              // funct3[0] picks clear over set
              if (funct3[0]) begin
                vstart_d = vstart_q & ~vlen_t'(csr_src);
              end else begin
                vstart_d = vstart_q | vlen_t'(csr_src);
              end
              result = XLEN'(vstart_q);
            end
            CSR_VL: begin
              if (rs1_idx == '0) result = XLEN'(vl_q);
              else err = 1'b1;
            end
            CSR_VTYPE: begin
              if (rs1_idx == '0) result = vtype_to_xlen(vtype_q);
              else err = 1'b1;
            end
            CSR_VLENB: begin
              if (rs1_idx == '0) result = XLEN'(VLENB);
              else err = 1'b1;
            end
            default: err = 1'b1;
          endcase
        end
        default: err = 1'b1;
      endcase
    end
  end

  assign verdict.claim      = claim;
  assign verdict.ready      = claim;
  assign verdict.resp_valid = claim;
  assign verdict.error      = err;
  assign verdict.result     = result;

  // Commit only when the core takes the answer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vstart_q <= '0;
      vl_q     <= '0;
      vtype_q  <= vtype_t'({1'b1, 8'b0});
    end else if (verdict.go && claim) begin
      vstart_q <= vstart_d;
      vl_q     <= vl_d;
      vtype_q  <= vtype_d;
    end
  end

  assign vl_o     = vl_q;
  assign vstart_o = vstart_q;
  assign vtype_o  = vtype_q;

  a_vl_max: assert property (@(posedge clk_i) disable iff (!rst_ni) vl_q <= vlen_t'(VLEN));

endmodule

`default_nettype wire

/* design/vinsn_decoder.sv */
//====================
// vadd and vector loads/stores to the backend
// One memory op in flight, answered when the backend responds
//====================
`timescale 1ns/1ps
`default_nettype none

module vinsn_decoder (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [31:0]                insn_i,
  input  logic [vdisp_pkg::XLEN-1:0] rs1_i,
  input  logic [vdisp_pkg::XLEN-1:0] rs2_i,
  input  vdisp_pkg::vlen_t           vl_i,
  input  vdisp_pkg::vlen_t           vstart_i,
  input  vdisp_pkg::vtype_t          vtype_i,
  vdisp_verdict_if.unit              verdict,
  output vdisp_pkg::ara_req_t        ara_req_o,
  output logic                       ara_req_valid_o,
  input  logic                       ara_req_ready_i,
  input  logic                       ara_resp_valid_i,
  input  logic                       ara_resp_error_i
);
  import vdisp_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [4:0] rd_idx;
  logic [4:0] rs2_idx;
  logic [1:0] mop;
  logic       is_arith;
  logic       is_load;
  logic       is_store;
  logic       claim;
  ara_req_t   req_d;
  logic       dec_err;
  logic       issue;
  logic       ready;
  logic       resp_valid;
  logic       error;
  logic       pending_q;
  logic       done_q;
  logic       done_err_q;
  logic       resp_hit;
  logic       resp_err;

  assign opcode   = insn_i[6:0];
  assign rd_idx   = insn_i[11:7];
  assign funct3   = insn_i[14:12];
  assign rs2_idx  = insn_i[24:20];
  assign mop      = insn_i[27:26];
  assign is_arith = (opcode == OPC_VEC) && (funct3 == F3_OPIVV);
  assign is_load  = (opcode == OPC_LOAD_FP);
  assign is_store = (opcode == OPC_STORE_FP);
  assign claim    = is_arith || is_load || is_store;

  always_comb begin
    req_d        = '0;
    req_d.vl     = vl_i;
    req_d.vstart = vstart_i;
    req_d.vtype  = vtype_i;
    req_d.vm     = insn_i[25];
    dec_err      = 1'b0;
    if (is_arith) begin
      req_d.op      = VADD;
      req_d.vs1     = insn_i[19:15];
      req_d.vs2     = rs2_idx;
      req_d.vd      = rd_idx;
      req_d.use_vs1 = 1'b1;
      req_d.use_vs2 = 1'b1;
      req_d.use_vd  = 1'b1;
      dec_err       = vtype_i.vill || (insn_i[31:26] != 6'b000000);
    end else if (is_load || is_store) begin
      req_d.scalar_op = rs1_i;
      if (is_load) begin
        req_d.vd     = rd_idx;
        req_d.use_vd = 1'b1;
      end else begin
        // vs3 sits where rd would be
        req_d.vs1     = rd_idx;
        req_d.use_vs1 = 1'b1;
      end
      case (mop)
        2'b00: begin
          req_d.op = is_load ? VLE : VSE;
          // Whole-register and fault-only-first forms are reserved here
          if (rs2_idx != 5'b00000) dec_err = 1'b1;
        end
        2'b10: begin
          req_d.op     = is_load ? VLSE : VSSE;
          req_d.stride = rs2_i;
        end
        default: begin
          req_d.op      = is_load ? VLXE : VSXE;
          req_d.vs2     = rs2_idx;
          req_d.use_vs2 = 1'b1;
          if (is_load && mop == 2'b01) dec_err = 1'b1;
        end
      endcase
      case ({insn_i[28], funct3})
        4'b0000: req_d.vtype.vsew = EW8;
        4'b0101: req_d.vtype.vsew = EW16;
        4'b0110: req_d.vtype.vsew = EW32;
        4'b0111: req_d.vtype.vsew = EW64;
        default: dec_err = 1'b1;
      endcase
    end
  end

  // Backend answer, live or parked while the core was stalled
  assign resp_hit = ara_resp_valid_i || done_q;
  assign resp_err = done_q ? done_err_q : ara_resp_error_i;

  always_comb begin
    ready      = 1'b0;
    resp_valid = 1'b0;
    error      = 1'b0;
    issue      = 1'b0;
    if (claim) begin
      if (dec_err) begin
        ready      = 1'b1;
        resp_valid = 1'b1;
        error      = 1'b1;
      end else if (is_arith) begin
        ready      = ara_req_ready_i;
        resp_valid = ara_req_ready_i;
        issue      = verdict.go && ara_req_ready_i;
      end else if (pending_q) begin
        ready      = resp_hit;
        resp_valid = resp_hit;
        error      = resp_err;
      end else begin
        // First sight of a memory op, send it and wait
        issue = verdict.go && ara_req_ready_i;
      end
    end
  end

  assign verdict.claim      = claim;
  assign verdict.ready      = ready;
  assign verdict.resp_valid = resp_valid;
  assign verdict.error      = error;
  assign verdict.result     = '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ara_req_valid_o <= 1'b0;
    end else if (ara_req_ready_i) begin
      ara_req_valid_o <= issue;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ara_req_ready_i) begin
      ara_req_o <= req_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q  <= 1'b0;
      done_q     <= 1'b0;
      done_err_q <= 1'b0;
    end else if (issue && !is_arith) begin
      pending_q <= 1'b1;
    end else if (pending_q && verdict.go && resp_hit) begin
      pending_q <= 1'b0;
      done_q    <= 1'b0;
    end else if (pending_q && ara_resp_valid_i) begin
      done_q     <= 1'b1;
      done_err_q <= ara_resp_error_i;
    end
  end

  a_no_req_while_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pending_q && $past(pending_q) |-> !$rose(ara_req_valid_o));

endmodule

`default_nettype wire

/* design/vdisp_ack.sv */
//====================
// Picks the claiming unit's verdict
// Unclaimed opcodes get an immediate illegal-instruction error
//====================
`timescale 1ns/1ps
`default_nettype none

module vdisp_ack (
  input  logic                       acc_req_valid_i,
  input  logic                       acc_resp_ready_i,
  vdisp_verdict_if.ack               csr_verdict,
  vdisp_verdict_if.ack               dec_verdict,
  output logic                       acc_req_ready_o,
  output logic                       acc_resp_valid_o,
  output logic                       acc_resp_error_o,
  output logic [vdisp_pkg::XLEN-1:0] acc_resp_result_o
);

  logic go;

  // No response can be taken while the core stalls
  assign go             = acc_req_valid_i && acc_resp_ready_i;
  assign csr_verdict.go = go;
  assign dec_verdict.go = go;

  always_comb begin
    acc_req_ready_o   = 1'b0;
    acc_resp_valid_o  = 1'b0;
    acc_resp_error_o  = 1'b0;
    acc_resp_result_o = '0;
    if (go) begin
      if (csr_verdict.claim) begin
        acc_req_ready_o   = csr_verdict.ready;
        acc_resp_valid_o  = csr_verdict.resp_valid;
        acc_resp_error_o  = csr_verdict.error;
        acc_resp_result_o = csr_verdict.result;
      end else if (dec_verdict.claim) begin
        acc_req_ready_o   = dec_verdict.ready;
        acc_resp_valid_o  = dec_verdict.resp_valid;
        acc_resp_error_o  = dec_verdict.error;
        acc_resp_result_o = dec_verdict.result;
      end else begin
        acc_req_ready_o  = 1'b1;
        acc_resp_valid_o = 1'b1;
        acc_resp_error_o = 1'b1;
      end
    end
  end

  // Opcode sets of the two units must stay disjoint
  always_comb begin
    a_one_claim: assert final (!(acc_req_valid_i && csr_verdict.claim && dec_verdict.claim));
  end

endmodule

`default_nettype wire

/* design/vdisp_top.sv */
//====================
// Vector dispatcher between scalar core and vector backend
// Core must hold an instruction until acc_req_ready_o
//====================
`timescale 1ns/1ps
`default_nettype none

module vdisp_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [31:0]                acc_insn_i,
  input  logic [vdisp_pkg::XLEN-1:0] acc_rs1_i,
  input  logic [vdisp_pkg::XLEN-1:0] acc_rs2_i,
  input  logic [3:0]                 acc_trans_id_i,
  input  logic                       acc_req_valid_i,
  output logic                       acc_req_ready_o,
  output logic [vdisp_pkg::XLEN-1:0] acc_resp_result_o,
  output logic                       acc_resp_error_o,
  output logic [3:0]                 acc_resp_trans_id_o,
  output logic                       acc_resp_valid_o,
  input  logic                       acc_resp_ready_i,
  output vdisp_pkg::ara_req_t        ara_req_o,
  output logic                       ara_req_valid_o,
  input  logic                       ara_req_ready_i,
  input  logic                       ara_resp_valid_i,
  input  logic                       ara_resp_error_i
);
  import vdisp_pkg::*;

  vlen_t  vl;
  vlen_t  vstart;
  vtype_t vtype;

  vdisp_verdict_if csr_verdict ();
  vdisp_verdict_if dec_verdict ();

  vcsr_unit i_vcsr_unit (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .insn_i   (acc_insn_i),
    .rs1_i    (acc_rs1_i),
    .rs2_i    (acc_rs2_i),
    .verdict  (csr_verdict.unit),
    .vl_o     (vl),
    .vstart_o (vstart),
    .vtype_o  (vtype)
  );

  vinsn_decoder i_vinsn_decoder (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .insn_i           (acc_insn_i),
    .rs1_i            (acc_rs1_i),
    .rs2_i            (acc_rs2_i),
    .vl_i             (vl),
    .vstart_i         (vstart),
    .vtype_i          (vtype),
    .verdict          (dec_verdict.unit),
    .ara_req_o        (ara_req_o),
    .ara_req_valid_o  (ara_req_valid_o),
    .ara_req_ready_i  (ara_req_ready_i),
    .ara_resp_valid_i (ara_resp_valid_i),
    .ara_resp_error_i (ara_resp_error_i)
  );

  vdisp_ack i_vdisp_ack (
    .acc_req_valid_i   (acc_req_valid_i),
    .acc_resp_ready_i  (acc_resp_ready_i),
    .csr_verdict       (csr_verdict.ack),
    .dec_verdict       (dec_verdict.ack),
    .acc_req_ready_o   (acc_req_ready_o),
    .acc_resp_valid_o  (acc_resp_valid_o),
    .acc_resp_error_o  (acc_resp_error_o),
    .acc_resp_result_o (acc_resp_result_o)
  );

  // Response always carries the id of the instruction on the bus
  assign acc_resp_trans_id_o = acc_trans_id_i;

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
//====================
// 10 ns clock, active-low reset held for 8 cycles
//====================
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    rst_no <= 1'b1;
  end

  always #5 clk_o = ~clk_o;

endmodule

`default_nettype wire

/* sim/tb_vdisp_model.svh */
//====================
// Behavioral model of the dispatcher state and backend requests
// Included in the testbench module body, needs vdisp_pkg imported
//====================
`ifndef TB_VDISP_MODEL_SVH
`define TB_VDISP_MODEL_SVH

vlen_t  m_vl;
vlen_t  m_vstart;
vtype_t m_vtype;

// VLMAX in elements for LMUL * VLENB / SEW
function automatic int model_vlmax(vtype_t vt);
  int sew_bytes;
  sew_bytes = 1 << vt.vsew;
  if (vt.vlmul2) return VLENB / sew_bytes / (1 << (4 - vt.vlmul));
  return VLENB * (1 << vt.vlmul) / sew_bytes;
endfunction

function automatic bit model_vtype_ok(vtype_t vt);
  int sew_bytes;
  sew_bytes = 1 << vt.vsew;
  if (vt.vsew > 3) return 1'b0;
  if ({vt.vlmul2, vt.vlmul} == 3'b100) return 1'b0;
  // Fractional LMUL must still hold one SEW element per ELEN
  if (vt.vlmul2 && sew_bytes * (1 << (4 - vt.vlmul)) > ELENB) return 1'b0;
  return 1'b1;
endfunction

function automatic void model_cfg(input logic [31:0] insn, input logic [63:0] rs1,
                                  input logic [63:0] rs2, output bit err,
                                  output logic [63:0] res);
  vtype_t vt;
  int     vlmax;
  err = 1'b0;
  res = '0;
  if (insn[31] && insn[31:25] != 7'b100_0000) begin
    err = 1'b1;
    return;
  end
  vt = insn[31] ? vtype_t'({1'b0, rs2[7:0]}) : vtype_t'({1'b0, insn[27:20]});
  if (!model_vtype_ok(vt)) begin
    m_vtype = vtype_t'(9'h100);
    m_vl    = '0;
  end else begin
    vlmax   = model_vlmax(vt);
    m_vtype = vt;
    if (insn[19:15] != 0) begin
      m_vl = (rs1 < 64'(vlmax)) ? vlen_t'(rs1) : vlen_t'(vlmax);
    end else if (insn[11:7] != 0) begin
      m_vl = vlen_t'(vlmax);
    end
  end
  res = 64'(m_vl);
endfunction

function automatic void model_csr(input logic [31:0] insn, input logic [63:0] rs1,
                                  output bit err, output logic [63:0] res);
  logic [2:0]  f3;
  logic [11:0] addr;
  vlen_t       src;
  f3   = insn[14:12];
  addr = insn[31:20];
  src  = f3[2] ? vlen_t'(insn[19:15]) : vlen_t'(rs1);
  err  = 1'b0;
  res  = '0;
  if (f3[1:0] == 2'b00) begin
    err = 1'b1;
  end else if (addr == CSR_VSTART) begin
    res = 64'(m_vstart);
    case (f3[1:0])
      2'b01:   m_vstart = src;
      2'b10:   m_vstart = m_vstart | src;
      default: m_vstart = m_vstart & ~src;
    endcase
  end else if (f3[1:0] == 2'b01 || insn[19:15] != 0) begin
    err = 1'b1;
  end else if (addr == CSR_VL) begin
    res = 64'(m_vl);
  end else if (addr == CSR_VTYPE) begin
    res = {m_vtype.vill, 55'b0, m_vtype[7:0]};
  end else if (addr == CSR_VLENB) begin
    res = 64'(VLENB);
  end else begin
    err = 1'b1;
  end
endfunction

// vadd and memory ops, only requests without err reach the backend
function automatic void model_vec(input logic [31:0] insn, input logic [63:0] rs1,
                                  input logic [63:0] rs2, output bit err,
                                  output bit mem, output ara_req_t req);
  bit         ld;
  logic [3:0] w;
  req        = '0;
  req.vl     = m_vl;
  req.vstart = m_vstart;
  req.vtype  = m_vtype;
  req.vm     = insn[25];
  mem        = (insn[6:0] != OPC_VEC);
  err        = 1'b0;
  if (!mem) begin
    req.op      = VADD;
    req.vs1     = insn[19:15];
    req.vs2     = insn[24:20];
    req.vd      = insn[11:7];
    req.use_vs1 = 1'b1;
    req.use_vs2 = 1'b1;
    req.use_vd  = 1'b1;
    err         = m_vtype.vill || insn[31:26] != 0;
    return;
  end
  ld            = (insn[6:0] == OPC_LOAD_FP);
  req.scalar_op = rs1;
  if (ld) begin
    req.vd     = insn[11:7];
    req.use_vd = 1'b1;
  end else begin
    req.vs1     = insn[11:7];
    req.use_vs1 = 1'b1;
  end
  if (insn[27:26] == 2'b00) begin
    req.op = ld ? VLE : VSE;
    err    = insn[24:20] != 0;
  end else if (insn[27:26] == 2'b10) begin
    req.op     = ld ? VLSE : VSSE;
    req.stride = rs2;
  end else begin
    req.op      = ld ? VLXE : VSXE;
    req.vs2     = insn[24:20];
    req.use_vs2 = 1'b1;
    err         = ld && insn[27:26] == 2'b01;
  end
  w = {insn[28], insn[14:12]};
  if (w == 4'b0000) req.vtype.vsew = EW8;
  else if (w[3:2] == 2'b01 && w[1:0] != 0) req.vtype.vsew = vew_e'(w[1:0]);
  else err = 1'b1;
endfunction

`endif

/* sim/tb_vdisp.sv */
//====================
// Random instructions checked against a behavioral model
// Backend answers memory requests after 1 to 8 cycles
//====================
`timescale 1ns/1ps
`default_nettype none

module tb_vdisp;
  import vdisp_pkg::*;

  localparam int N_RAND     = 400;
  localparam int RST_CYCLES = 8;
  // Each random instruction brings at most two read-backs
  localparam int MAX_INSN   = 3 * N_RAND;

  logic            clk;
  logic            rst_n;
  logic [31:0]     acc_insn;
  logic [63:0]     acc_rs1;
  logic [63:0]     acc_rs2;
  logic [3:0]      acc_trans_id;
  logic            acc_req_valid;
  logic            acc_req_ready;
  logic [63:0]     acc_resp_result;
  logic            acc_resp_error;
  logic [3:0]      acc_resp_trans_id;
  logic            acc_resp_valid;
  logic            acc_resp_ready;
  ara_req_t        ara_req;
  logic            ara_req_valid;
  logic            ara_req_ready;
  logic            ara_resp_valid;
  logic            ara_resp_error;

  integer          seed;
  int              n_checks;
  int              n_errors;
  int              resp_cnt;
  logic [3:0]      next_id;
  logic            bk_err;
  logic            bk_done;
  ara_req_t        exp_q[$];
  string           name_q[$];

  tb_clk_gen i_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  vdisp_top i_vdisp_top (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .acc_insn_i          (acc_insn),
    .acc_rs1_i           (acc_rs1),
    .acc_rs2_i           (acc_rs2),
    .acc_trans_id_i      (acc_trans_id),
    .acc_req_valid_i     (acc_req_valid),
    .acc_req_ready_o     (acc_req_ready),
    .acc_resp_result_o   (acc_resp_result),
    .acc_resp_error_o    (acc_resp_error),
    .acc_resp_trans_id_o (acc_resp_trans_id),
    .acc_resp_valid_o    (acc_resp_valid),
    .acc_resp_ready_i    (acc_resp_ready),
    .ara_req_o           (ara_req),
    .ara_req_valid_o     (ara_req_valid),
    .ara_req_ready_i     (ara_req_ready),
    .ara_resp_valid_i    (ara_resp_valid),
    .ara_resp_error_i    (ara_resp_error)
  );

  `include "tb_vdisp_model.svh"

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  task automatic check_val(input string name, input logic [191:0] expected,
                           input logic [191:0] actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // Random stalls on both sides, and the backend responder
  always @(posedge clk) begin : backend_side
    logic [31:0] draw;
    acc_resp_ready <= (rand_word() & 3) != 0;
    ara_req_ready  <= (rand_word() & 3) != 0;
    ara_resp_valid <= 1'b0;
    if (resp_cnt == 1) begin
      draw = rand_word();
      ara_resp_valid <= 1'b1;
      ara_resp_error <= draw[0];
      bk_err         <= draw[0];
      bk_done        <= 1'b1;
    end
    if (resp_cnt > 0) resp_cnt <= resp_cnt - 1;
    if (ara_req_valid && ara_req_ready && ara_req.op != VADD) begin
      resp_cnt <= 1 + (rand_word() & 7);
    end
  end

  // Each backend handshake takes the oldest expected request
  always @(negedge clk) begin
    if (rst_n && ara_req_valid && ara_req_ready) begin
      if (exp_q.size() == 0) begin
        n_errors++;
        $display("Backend request %0h sent with no instruction that should issue it", ara_req);
      end else begin
        check_val({name_q.pop_front(), " request"}, exp_q.pop_front(), ara_req);
      end
    end
  end

  task automatic run_insn(input string name, input logic [31:0] insn,
                          input logic [63:0] rs1, input logic [63:0] rs2);
    bit          err;
    bit          mem;
    logic [63:0] res;
    ara_req_t    req;
    logic [3:0]  id;
    @(posedge clk);
    res = '0;
    mem = 1'b0;
    if (insn[6:0] == OPC_SYSTEM) begin
      model_csr(insn, rs1, err, res);
    end else if (insn[6:0] == OPC_VEC && insn[14:12] == F3_OPCFG) begin
      model_cfg(insn, rs1, rs2, err, res);
    end else if ((insn[6:0] == OPC_VEC && insn[14:12] == F3_OPIVV) ||
                 insn[6:0] == OPC_LOAD_FP || insn[6:0] == OPC_STORE_FP) begin
      model_vec(insn, rs1, rs2, err, mem, req);
      if (!err) begin
        exp_q.push_back(req);
        name_q.push_back(name);
      end
    end else begin
      err = 1'b1;
    end
    mem           = mem && !err;
    id            = next_id;
    next_id       = next_id + 1;
    acc_insn      <= insn;
    acc_rs1       <= rs1;
    acc_rs2       <= rs2;
    acc_trans_id  <= id;
    acc_req_valid <= 1'b1;
    @(negedge clk);
    while (!acc_req_ready) begin
      if (acc_resp_valid) begin
        n_errors++;
        $display("Response valid without ready during %s", name);
      end
      @(negedge clk);
    end
    if (mem && !bk_done) begin
      n_errors++;
      $display("%s answered before the backend responded", name);
    end
    if (mem) err = bk_err;
    check_val({name, " valid"}, 1, acc_resp_valid);
    check_val({name, " error"}, err, acc_resp_error);
    check_val({name, " result"}, res, acc_resp_result);
    check_val({name, " trans_id"}, id, acc_resp_trans_id);
    bk_done = 1'b0;
  endtask

  task automatic read_csr(input string name, input logic [11:0] addr);
    run_insn(name, {addr, 5'd0, 3'b010, 5'd1, OPC_SYSTEM}, '0, '0);
  endtask

  task automatic run_random(input int kind);
    logic [31:0] r;
    logic [31:0] s;
    logic [4:0]  rd;
    logic [4:0]  rs1i;
    logic [4:0]  rs2f;
    logic [3:0]  width;
    logic [11:0] addr;
    logic [6:0]  opc;
    logic [2:0]  f3;
    r    = rand_word();
    s    = rand_word();
    rd   = (r[1:0] == 0) ? 5'd0 : r[6:2];
    rs1i = (r[8:7] == 0) ? 5'd0 : r[13:9];
    case (kind)
      0: begin
        run_insn("vsetvli", {4'b0, s[7:0], rs1i, F3_OPCFG, rd, OPC_VEC}, 64'(s[17:8]), '0);
        read_csr("read vl", CSR_VL);
        read_csr("read vtype", CSR_VTYPE);
      end
      1: begin
        run_insn("vsetvl", {1'b1, (r[21:19] == 0) ? r[27:22] : 6'b0, r[18:14], rs1i,
                 F3_OPCFG, rd, OPC_VEC}, 64'(s[17:8]), 64'(s[7:0]));
        read_csr("read vl", CSR_VL);
        read_csr("read vtype", CSR_VTYPE);
      end
      2: begin
        case (r[21:19])
          3'd0, 3'd1: addr = CSR_VSTART;
          3'd2:       addr = CSR_VL;
          3'd3:       addr = CSR_VTYPE;
          3'd4:       addr = CSR_VLENB;
          default:    addr = {r[31:22], 2'b11};
        endcase
        run_insn("csr", {addr, rs1i, s[20:18], rd, OPC_SYSTEM}, 64'(s[17:8]), '0);
        read_csr("read vstart", CSR_VSTART);
      end
      3: begin
        run_insn("vadd", {(r[21:19] == 0) ? r[27:22] : 6'b0, s[0], r[18:14], rs1i,
                 F3_OPIVV, rd, OPC_VEC}, '0, '0);
      end
      4, 5: begin
        if (s[1:0] != 0) width = (s[3:2] == 0) ? 4'b0000 : {2'b01, s[3:2]};
        else width = s[5:2];
        // Mostly legal lumop on unit-stride
        rs2f = (s[7:6] == 2'b00 && r[21:20] != 0) ? 5'd0 : r[18:14];
        opc  = (kind == 4) ? OPC_LOAD_FP : OPC_STORE_FP;
        run_insn((kind == 4) ? "load" : "store",
                 {3'b000, width[3], s[7:6], s[8], rs2f, rs1i, width[2:0], rd, opc},
                 {rand_word(), rand_word()}, {r, s});
      end
      default: begin
        opc = s[6:0];
        if (opc == OPC_VEC || opc == OPC_SYSTEM || opc == OPC_LOAD_FP ||
            opc == OPC_STORE_FP) begin
          opc = 7'b0110011;
        end
        f3 = (s[9:7] == 3'd0 || s[9:7] == 3'd7) ? 3'b011 : s[9:7];
        if (r[0]) run_insn("illegal", {r[31:15], f3, r[11:7], OPC_VEC}, '0, '0);
        else run_insn("illegal", {r[31:7], opc}, '0, '0);
      end
    endcase
  endtask

  initial begin
    seed           = 32'h10f4;
    n_checks       = 0;
    n_errors       = 0;
    resp_cnt       = 0;
    next_id        = '0;
    bk_err         = 1'b0;
    bk_done        = 1'b0;
    acc_insn       = '0;
    acc_rs1        = '0;
    acc_rs2        = '0;
    acc_trans_id   = '0;
    acc_req_valid  = 1'b0;
    acc_resp_ready = 1'b0;
    ara_req_ready  = 1'b0;
    ara_resp_valid = 1'b0;
    ara_resp_error = 1'b0;
    m_vl           = '0;
    m_vstart       = '0;
    m_vtype        = vtype_t'(9'h100);
    @(posedge rst_n);
    @(negedge clk);
    read_csr("vlenb", CSR_VLENB);
    for (int i = 0; i < N_RAND; i++) begin
      run_random($unsigned(rand_word()) % 7);
    end
    @(posedge clk);
    acc_req_valid <= 1'b0;
    repeat (20) @(posedge clk);
    if (exp_q.size() != 0) begin
      n_errors++;
      $display("%0d expected backend requests never appeared", exp_q.size());
    end
    $display("Checks: %0d  Errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (MAX_INSN * 20 + RST_CYCLES) @(posedge clk);
    $display("Watchdog expired, the DUT stopped accepting instructions");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+sim
design/vdisp_pkg.sv
design/vdisp_verdict_if.sv
design/vcsr_unit.sv
design/vinsn_decoder.sv
design/vdisp_ack.sv
design/vdisp_top.sv
sim/tb_clk_gen.sv
sim/tb_vdisp.sv
